//--- src/rx_front_pkg.sv
package rx_front_pkg;

    // ----------------------------------------------------------------------
    // sample format
    // ----------------------------------------------------------------------

    // one real or imaginary component
    localparam int SAMPLE_DW = 16;
    // complex sample, imag in upper half, real in lower half
    localparam int IQ_DW = 2 * SAMPLE_DW;

    // ----------------------------------------------------------------------
    // derotator, CIC and alignment
    // ----------------------------------------------------------------------

    // phase accumulator and offset word
    localparam int PHASE_DW = 20;

    localparam int CIC_STAGES = 3;
    localparam int CIC_RATE = 2;
    // growth of N * log2(R * M) bits
    localparam int CIC_ACC_DW = SAMPLE_DW + CIC_STAGES;

    // stages ahead of frame timing
    localparam int DELAY_LEN = 14;

    // ----------------------------------------------------------------------
    // vector types
    // ----------------------------------------------------------------------

    typedef logic signed [SAMPLE_DW-1:0] sample_t;
    typedef logic [IQ_DW-1:0] iq_sample_t;
    typedef logic signed [PHASE_DW-1:0] phase_t;
    typedef logic signed [CIC_ACC_DW-1:0] cic_acc_t;

endpackage

//--- src/cfo_derotator.sv
`timescale 1ns/1ps

module cfo_derotator (
    input  logic                     clk_i,
    input  logic                     reset_ni,

    input  rx_front_pkg::iq_sample_t sample_i,
    input  logic                     sample_valid_i,

    input  rx_front_pkg::phase_t     cfo_inc_i,
    input  logic                     cfo_valid_i,

    output rx_front_pkg::iq_sample_t derot_o,
    output logic                     derot_valid_o
);

    // total offset and running phase
    rx_front_pkg::phase_t  freq_q;
    rx_front_pkg::phase_t  phase_q;

    rx_front_pkg::sample_t in_re;
    rx_front_pkg::sample_t in_im;
    rx_front_pkg::sample_t rot_re;
    rx_front_pkg::sample_t rot_im;
    logic [1:0]            quadrant;

    // -x, with the most negative value clipped to the most positive
    function automatic rx_front_pkg::sample_t neg_sat(input rx_front_pkg::sample_t x);
        rx_front_pkg::sample_t res;
        res = -x;
        if (x[rx_front_pkg::SAMPLE_DW-1] && (x[rx_front_pkg::SAMPLE_DW-2:0] == '0)) begin
            res = ~x;
        end
        return res;
    endfunction

    assign in_re = sample_i[rx_front_pkg::SAMPLE_DW-1:0];
    assign in_im = sample_i[rx_front_pkg::IQ_DW-1:rx_front_pkg::SAMPLE_DW];

    // top two phase bits select the quarter turn
    assign quadrant = phase_q[rx_front_pkg::PHASE_DW-1 -: 2];

    // ----------------------------------------------------------------------
    // quarter-turn rotation
    // ----------------------------------------------------------------------
    always_comb begin
        case (quadrant)
            2'd0: begin
                rot_re = in_re;
                rot_im = in_im;
            end
            2'd1: begin
                rot_re = in_im;
                rot_im = neg_sat(in_re);
            end
            2'd2: begin
                rot_re = neg_sat(in_re);
                rot_im = neg_sat(in_im);
            end
            default: begin
                rot_re = neg_sat(in_im);
                rot_im = in_re;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // offset, phase and output registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            freq_q        <= '0;
            phase_q       <= '0;
            derot_o       <= '0;
            derot_valid_o <= 1'b0;
        end else begin
            // updates are relative to the previous one
            if (cfo_valid_i) begin
                freq_q <= freq_q - cfo_inc_i;
            end

            // old offset applies when both strobes coincide
            if (sample_valid_i) begin
                phase_q <= phase_q + freq_q;
                derot_o <= {rot_im, rot_re};
            end

            derot_valid_o <= sample_valid_i;
        end
    end

endmodule

//--- src/cic_decimator.sv
`timescale 1ns/1ps

module cic_decimator (
    input  logic                  clk_i,
    input  logic                  reset_ni,

    input  rx_front_pkg::sample_t in_i,
    input  logic                  in_valid_i,

    output rx_front_pkg::sample_t out_o,
    output logic                  out_valid_o
);

    // integrator state and next values
    rx_front_pkg::cic_acc_t integ_q [rx_front_pkg::CIC_STAGES];
    rx_front_pkg::cic_acc_t integ_d [rx_front_pkg::CIC_STAGES];

    // comb delays, one decimated sample each
    rx_front_pkg::cic_acc_t comb_dly_q [rx_front_pkg::CIC_STAGES];
    rx_front_pkg::cic_acc_t comb_val [rx_front_pkg::CIC_STAGES + 1];

    // position inside the decimation group
    logic [$clog2(rx_front_pkg::CIC_RATE)-1:0] dec_phase_q;
    logic                                      dec_hit;

    assign dec_hit = in_valid_i && (dec_phase_q == rx_front_pkg::CIC_RATE - 1);

    // ----------------------------------------------------------------------
    // integrators
    // ----------------------------------------------------------------------

    // current input already included, so the comb sees x[n]
    always_comb begin
        integ_d[0] = integ_q[0] + rx_front_pkg::cic_acc_t'(in_i);
        for (int k = 1; k < rx_front_pkg::CIC_STAGES; k++) begin
            integ_d[k] = integ_q[k] + integ_d[k-1];
        end
    end

    // ----------------------------------------------------------------------
    // combs
    // ----------------------------------------------------------------------
    always_comb begin
        comb_val[0] = integ_d[rx_front_pkg::CIC_STAGES-1];
        for (int k = 0; k < rx_front_pkg::CIC_STAGES; k++) begin
            comb_val[k+1] = comb_val[k] - comb_dly_q[k];
        end
    end

    // ----------------------------------------------------------------------
    // state and output
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int k = 0; k < rx_front_pkg::CIC_STAGES; k++) begin
                integ_q[k]    <= '0;
                comb_dly_q[k] <= '0;
            end
            dec_phase_q <= '0;
            out_o       <= '0;
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= dec_hit;

            if (in_valid_i) begin
                for (int k = 0; k < rx_front_pkg::CIC_STAGES; k++) begin
                    integ_q[k] <= integ_d[k];
                end

                if (dec_phase_q == rx_front_pkg::CIC_RATE - 1) begin
                    dec_phase_q <= '0;
                end else begin
                    dec_phase_q <= dec_phase_q + 1'b1;
                end
            end

            if (dec_hit) begin
                for (int k = 0; k < rx_front_pkg::CIC_STAGES; k++) begin
                    comb_dly_q[k] <= comb_val[k];
                end
                // drop the gain bits, (R*M)^N = 8
                out_o <= comb_val[rx_front_pkg::CIC_STAGES][rx_front_pkg::CIC_ACC_DW-1 -:
                                                             rx_front_pkg::SAMPLE_DW];
            end
        end
    end

endmodule

//--- src/align_delay_line.sv
`timescale 1ns/1ps

module align_delay_line (
    input  logic                     clk_i,
    input  logic                     reset_ni,

    input  rx_front_pkg::iq_sample_t in_i,
    input  logic                     in_valid_i,

    output rx_front_pkg::iq_sample_t out_o,
    output logic                     out_valid_o
);

    rx_front_pkg::iq_sample_t         data_q [rx_front_pkg::DELAY_LEN];
    logic [rx_front_pkg::DELAY_LEN-1:0] valid_q;

    // ----------------------------------------------------------------------
    // shift every cycle, gaps travel along with the data
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int i = 0; i < rx_front_pkg::DELAY_LEN; i++) begin
                data_q[i] <= '0;
            end
            valid_q <= '0;
        end else begin
            data_q[0] <= in_i;
            for (int i = 1; i < rx_front_pkg::DELAY_LEN; i++) begin
                data_q[i] <= data_q[i-1];
            end
            valid_q <= {valid_q[rx_front_pkg::DELAY_LEN-2:0], in_valid_i};
        end
    end

    // last stage
    assign out_o       = data_q[rx_front_pkg::DELAY_LEN-1];
    assign out_valid_o = valid_q[rx_front_pkg::DELAY_LEN-1];

endmodule

//--- src/rx_front.sv
`timescale 1ns/1ps

module rx_front (
    input  logic                     clk_i,
    input  logic                     reset_ni,

    // baseband samples
    input  rx_front_pkg::iq_sample_t sample_i,
    input  logic                     sample_valid_i,

    // relative offset update from cell search
    input  rx_front_pkg::phase_t     cfo_inc_i,
    input  logic                     cfo_valid_i,

    // to frame timing
    output rx_front_pkg::iq_sample_t delayed_o,
    output logic                     delayed_valid_o,

    // to correlator
    output rx_front_pkg::iq_sample_t decim_o,
    output logic                     decim_valid_o
);

    rx_front_pkg::iq_sample_t derot_data;
    logic                     derot_valid;

    rx_front_pkg::sample_t    decim_re;
    rx_front_pkg::sample_t    decim_im;

    // ----------------------------------------------------------------------
    // frequency correction
    // ----------------------------------------------------------------------
    cfo_derotator derot_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .cfo_inc_i      (cfo_inc_i),
        .cfo_valid_i    (cfo_valid_i),
        .derot_o        (derot_data),
        .derot_valid_o  (derot_valid)
    );

    // ----------------------------------------------------------------------
    // correlator path, one CIC per component
    // ----------------------------------------------------------------------
    cic_decimator cic_re (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_i        (derot_data[rx_front_pkg::SAMPLE_DW-1:0]),
        .in_valid_i  (derot_valid),
        .out_o       (decim_re),
        .out_valid_o (decim_valid_o)
    );

    // runs in lockstep with cic_re
    cic_decimator cic_im (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_i        (derot_data[rx_front_pkg::IQ_DW-1:rx_front_pkg::SAMPLE_DW]),
        .in_valid_i  (derot_valid),
        .out_o       (decim_im),
        .out_valid_o ()
    );

    assign decim_o = {decim_im, decim_re};

    // ----------------------------------------------------------------------
    // alignment path
    // ----------------------------------------------------------------------
    align_delay_line delay_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_i        (derot_data),
        .in_valid_i  (derot_valid),
        .out_o       (delayed_o),
        .out_valid_o (delayed_valid_o)
    );

endmodule

//--- tb/rx_front_asserts.sv
`timescale 1ns/1ps

module rx_front_asserts (
    input logic clk_i,
    input logic reset_ni,
    input logic sample_valid_i,
    input logic delayed_valid_o,
    input logic decim_valid_o
);

    // synchronous reset clears both strobes
    reset_clears_valids: assert property (
        @(posedge clk_i) !reset_ni |=> (!delayed_valid_o && !decim_valid_o)
    ) else $error("output valid high after a reset cycle");

    // one decimated output per two inputs
    decim_valid_spaced: assert property (
        @(posedge clk_i) disable iff (!reset_ni) decim_valid_o |=> !decim_valid_o
    ) else $error("decim_valid_o high in two cycles in a row");

    // derotator register plus the delay line
    delayed_valid_latency: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
            delayed_valid_o == $past(sample_valid_i, 15)
    ) else $error("delayed_valid_o does not follow sample_valid_i by 15 cycles");

endmodule

bind rx_front rx_front_asserts asserts_i (.*);

//--- tb/rx_front_checker.sv
`timescale 1ns/1ps

module rx_front_checker (
    input  logic                     clk_i,
    input  logic                     reset_ni,
    input  rx_front_pkg::iq_sample_t sample_i,
    input  logic                     sample_valid_i,
    input  rx_front_pkg::phase_t     cfo_inc_i,
    input  logic                     cfo_valid_i,
    input  rx_front_pkg::iq_sample_t delayed_o,
    input  logic                     delayed_valid_o,
    input  rx_front_pkg::iq_sample_t decim_o,
    input  logic                     decim_valid_o,
    output int                       error_count_o,
    output int                       check_count_o,
    output int                       pending_o
);

    // model of offset, phase and the last four derotated samples
    rx_front_pkg::phase_t freq_m;
    rx_front_pkg::phase_t phase_m;
    int re_hist [4];
    int im_hist [4];
    int valid_count;
    int cyc;

    // expected strobes, cycle of arrival and value
    int                       dly_cyc [$];
    rx_front_pkg::iq_sample_t dly_val [$];
    int                       dec_cyc [$];
    rx_front_pkg::iq_sample_t dec_val [$];

    initial begin
        error_count_o = 0;
        check_count_o = 0;
        pending_o     = 0;
        cyc           = 0;
    end

    // ------------------------------------------------------------------
    // reference functions
    // ------------------------------------------------------------------
    function automatic int negate_clip(input int x);
        int lowest;
        lowest = -(1 << (rx_front_pkg::SAMPLE_DW - 1));
        if (x == lowest) begin
            return -lowest - 1;
        end
        return -x;
    endfunction

    function automatic rx_front_pkg::iq_sample_t rotate_ref(
        input rx_front_pkg::iq_sample_t s,
        input logic [1:0]               q
    );
        int re;
        int im;
        int out_re;
        int out_im;
        re = int'(rx_front_pkg::sample_t'(s[rx_front_pkg::SAMPLE_DW-1:0]));
        im = int'(rx_front_pkg::sample_t'(s[rx_front_pkg::IQ_DW-1:rx_front_pkg::SAMPLE_DW]));
        out_re = (q == 2'd0) ? re : (q == 2'd1) ? im : (q == 2'd2) ? negate_clip(re)
                 : negate_clip(im);
        out_im = (q == 2'd0) ? im : (q == 2'd1) ? negate_clip(re)
                 : (q == 2'd2) ? negate_clip(im) : re;
        return {rx_front_pkg::sample_t'(out_im), rx_front_pkg::sample_t'(out_re)};
    endfunction

    // x0 is the newest valid input
    function automatic rx_front_pkg::sample_t cic_ref(input int x0, input int x1,
                                                       input int x2, input int x3);
        int sum;
        sum = x0 + 3 * x1 + 3 * x2 + x3;
        return rx_front_pkg::sample_t'(sum >>> 3);
    endfunction

    // ------------------------------------------------------------------
    // comparison
    // ------------------------------------------------------------------
    task automatic compare_value(input string name, input rx_front_pkg::iq_sample_t exp,
                                 input rx_front_pkg::iq_sample_t act);
        check_count_o++;
        if (act !== exp) begin
            $display("ERROR time %0t signal %s expected %h actual %h", $time, name, exp, act);
            error_count_o++;
        end
    endtask

    task automatic check_delayed();
        while (dly_cyc.size() > 0 && dly_cyc[0] < cyc) begin
            $display("time %0t: delayed_valid_o did not come for a sample", $time);
            error_count_o++;
            void'(dly_cyc.pop_front());
            void'(dly_val.pop_front());
        end
        if (delayed_valid_o) begin
            if (dly_cyc.size() == 0 || dly_cyc[0] != cyc) begin
                $display("time %0t: delayed_valid_o high with no sample due", $time);
                error_count_o++;
            end else begin
                compare_value("delayed_o", dly_val.pop_front(), delayed_o);
                void'(dly_cyc.pop_front());
            end
        end
    endtask

    task automatic check_decim();
        while (dec_cyc.size() > 0 && dec_cyc[0] < cyc) begin
            $display("time %0t: decim_valid_o did not come for a sample pair", $time);
            error_count_o++;
            void'(dec_cyc.pop_front());
            void'(dec_val.pop_front());
        end
        if (decim_valid_o) begin
            if (dec_cyc.size() == 0 || dec_cyc[0] != cyc) begin
                $display("time %0t: decim_valid_o high with no output due", $time);
                error_count_o++;
            end else begin
                compare_value("decim_o", dec_val.pop_front(), decim_o);
                void'(dec_cyc.pop_front());
            end
        end
    endtask

    task automatic model_sample();
        rx_front_pkg::iq_sample_t rot;
        rot = rotate_ref(sample_i, phase_m[rx_front_pkg::PHASE_DW-1 -: 2]);
        dly_cyc.push_back(cyc + 1 + rx_front_pkg::DELAY_LEN);
        dly_val.push_back(rot);
        for (int k = 3; k > 0; k--) begin
            re_hist[k] = re_hist[k-1];
            im_hist[k] = im_hist[k-1];
        end
        re_hist[0] = int'(rx_front_pkg::sample_t'(rot[rx_front_pkg::SAMPLE_DW-1:0]));
        im_hist[0] = int'(rx_front_pkg::sample_t'(rot[rx_front_pkg::IQ_DW-1:rx_front_pkg::SAMPLE_DW]));
        valid_count++;
        if (valid_count % rx_front_pkg::CIC_RATE == 0) begin
            dec_cyc.push_back(cyc + 2);
            dec_val.push_back({cic_ref(im_hist[0], im_hist[1], im_hist[2], im_hist[3]),
                               cic_ref(re_hist[0], re_hist[1], re_hist[2], re_hist[3])});
        end
        // old offset, even when an update arrives with this sample
        phase_m = phase_m + freq_m;
    endtask

    always @(posedge clk_i) begin
        if (!reset_ni) begin
            freq_m      = '0;
            phase_m     = '0;
            valid_count = 0;
            for (int k = 0; k < 4; k++) begin
                re_hist[k] = 0;
                im_hist[k] = 0;
            end
            dly_cyc.delete();
            dly_val.delete();
            dec_cyc.delete();
            dec_val.delete();
        end else begin
            check_delayed();
            check_decim();
            if (sample_valid_i) begin
                model_sample();
            end
            if (cfo_valid_i) begin
                freq_m = freq_m - cfo_inc_i;
            end
        end
        cyc++;
        pending_o = dly_cyc.size() + dec_cyc.size();
    end

endmodule

//--- tb/tb_rx_front.sv
`timescale 1ns/1ps

module tb_rx_front;

    logic                     clk_i;
    logic                     reset_ni;
    rx_front_pkg::iq_sample_t sample_i;
    logic                     sample_valid_i;
    rx_front_pkg::phase_t     cfo_inc_i;
    logic                     cfo_valid_i;
    rx_front_pkg::iq_sample_t delayed_o;
    logic                     delayed_valid_o;
    rx_front_pkg::iq_sample_t decim_o;
    logic                     decim_valid_o;

    int error_count;
    int check_count;
    int pending;
    int tests_run;
    int tests_failed;
    int errors_before;
    int cycle_count;
    int cycle_limit;

    // test lengths, the cycle budget follows from them
    int idle_len  = 40;
    int burst_len = 16;
    int gap_len   = 16;
    int rot_len   = 8;
    int rand_len  = 200;
    int sat_len   = 24;
    int drain_len = 24;

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    rx_front UUT (.*);

    rx_front_checker chk (
        .*,
        .error_count_o (error_count),
        .check_count_o (check_count),
        .pending_o     (pending)
    );

    initial begin
        cycle_limit = 16 + idle_len + burst_len + 4 * gap_len + 8 * rot_len
                      + 4 * rand_len + 4 * sat_len + 5 * drain_len + 100;
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout: the run did not end within %0d cycles", cycle_limit);
        $display("Some tests failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------
    function automatic rx_front_pkg::iq_sample_t pack_iq(input int re, input int im);
        return {rx_front_pkg::sample_t'(im), rx_front_pkg::sample_t'(re)};
    endfunction

    task automatic drive(input logic sv, input rx_front_pkg::iq_sample_t s,
                         input logic cv, input rx_front_pkg::phase_t inc);
        @(posedge clk_i);
        sample_valid_i <= sv;
        sample_i       <= s;
        cfo_valid_i    <= cv;
        cfo_inc_i      <= inc;
    endtask

    task automatic send_sample(input rx_front_pkg::iq_sample_t s);
        drive(1'b1, s, 1'b0, '0);
    endtask

    task automatic idle(input int n);
        repeat (n) drive(1'b0, '0, 1'b0, '0);
    endtask

    // waits until every expected strobe has been seen, then reports
    task automatic end_test(input string name);
        int errs;
        idle(1);
        @(negedge clk_i);
        while (pending != 0) @(negedge clk_i);
        idle(4);
        @(negedge clk_i);
        errs = error_count - errors_before;
        errors_before = error_count;
        tests_run++;
        if (errs == 0) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail with %0d errors", tests_run, name, errs);
        end
    endtask

    initial begin
        void'($urandom(32'ha8e06b3d));
        reset_ni       = 1'b0;
        sample_i       = '0;
        sample_valid_i = 1'b0;
        cfo_inc_i      = '0;
        cfo_valid_i    = 1'b0;
        tests_run      = 0;
        tests_failed   = 0;
        errors_before  = 0;
        repeat (16) @(posedge clk_i);
        reset_ni <= 1'b1;

        idle(idle_len);
        end_test("idle after reset");

        // no offset yet, so the delayed stream is the input stream
        for (int i = 0; i < burst_len; i++) begin
            send_sample(pack_iq(100 * i - 700, 3 - 50 * i));
        end
        for (int i = 0; i < gap_len; i++) begin
            send_sample(pack_iq(-9000 + 613 * i, 4200 - 271 * i));
            idle(1 + $urandom_range(2, 0));
        end
        end_test("pass-through");

        // quarter turn, then eighth turn set with a sample, then half turn
        drive(1'b0, '0, 1'b1, rx_front_pkg::phase_t'(-(1 << 18)));
        for (int i = 0; i < rot_len; i++) begin
            send_sample(pack_iq(1000 + 37 * i, -500 + 11 * i));
        end
        drive(1'b1, pack_iq(1234, -4321), 1'b1, rx_front_pkg::phase_t'(1 << 17));
        for (int i = 0; i < rot_len; i++) begin
            send_sample(pack_iq(-3000 + 401 * i, 2500 - 97 * i));
            idle(1);
        end
        drive(1'b0, '0, 1'b1, rx_front_pkg::phase_t'(-(3 << 17)));
        for (int i = 0; i < rot_len / 2; i++) begin
            send_sample(pack_iq(777 - 5 * i, 31000 - i));
        end
        end_test("offset rotation");

        for (int i = 0; i < rand_len; i++) begin
            send_sample(rx_front_pkg::iq_sample_t'($urandom()));
            idle($urandom_range(3, 0));
        end
        end_test("random decimation");

        // back to a quarter turn so each quadrant meets the most negative value
        drive(1'b0, '0, 1'b1, rx_front_pkg::phase_t'(1 << 18));
        for (int i = 0; i < sat_len; i++) begin
            if (i % 3 == 0) begin
                send_sample(pack_iq(-32768, -32768));
            end else if (i % 3 == 1) begin
                send_sample(pack_iq(-32768, 1234));
            end else begin
                send_sample(pack_iq(-77, -32768));
            end
        end
        end_test("saturation");

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- rx_front.f
src/rx_front_pkg.sv
src/cfo_derotator.sv
src/cic_decimator.sv
src/align_delay_line.sv
src/rx_front.sv
tb/rx_front_asserts.sv
tb/rx_front_checker.sv
tb/tb_rx_front.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rx_front
FILELIST  ?= rx_front.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard src/*.sv tb/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf $(BUILD_DIR)
